//--- icache.f
+incdir+hw
hw/icache_pkg.sv
hw/icache_ctrl.sv
hw/icache_data_ram.sv
hw/icache_top.sv
testbench/tb_axi_mem.sv
testbench/tb_icache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -j 0 \
    --timescale 1ns/100ps \
    --top-module tb_icache \
    -f icache.f

# the simulator exits non-zero on $fatal, the log decides the result
./obj_dir/Vtb_icache > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "run_sim: failure found in $LOG"
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "run_sim: simulation ended without a result"
    exit 1
fi
echo "run_sim: done"

//--- testbench/tb_icache.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module tb_icache
    import icache_pkg::*;
();

    // 333 requests in all, 200 cycles each before the watchdog fires
    localparam int NUM_REQS       = 333;
    localparam int CYCLES_PER_REQ = 200;

    // reference prediction for one accepted request
    typedef struct packed {
        logic      hit;
        cpu_resp_t resp;
        axi_ar_t   ar;
    } expect_t;

    logic      I_clk = 1'b0;
    logic      I_rst;
    logic      cpu_req_valid;
    cpu_req_t  cpu_req;
    logic      cpu_ready;
    logic      cpu_resp_valid;
    cpu_resp_t cpu_resp;
    logic      ar_valid;
    axi_ar_t   ar;
    logic      ar_ready;
    logic      r_valid;
    axi_r_t    r;

    // shadow tag / valid store
    logic                       ref_valid [`ICACHE_SETS][2];
    logic [`ICACHE_TAG_LEN-1:0] ref_tag   [`ICACHE_SETS][2];

    // outstanding requests, oldest first
    expect_t pending[$];
    string   pend_name[$];
    int      acc_cycle[$];
    string   test_name = "reset";
    int      cycle     = 0;
    int      ar_cnt    = 0;

    always #10 I_clk = ~I_clk;

    icache_top icache_top_inst (
        .I_clk          (I_clk),
        .I_rst          (I_rst),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req        (cpu_req),
        .cpu_ready      (cpu_ready),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp       (cpu_resp),
        .ar_valid       (ar_valid),
        .ar             (ar),
        .ar_ready       (ar_ready),
        .r_valid        (r_valid),
        .r              (r)
    );

    tb_axi_mem axi_mem_inst (
        .I_clk    (I_clk),
        .ar_valid (ar_valid),
        .ar       (ar),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r        (r)
    );

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // predicts outcome, word and ar, then updates the shadow on a miss
    function automatic expect_t ref_access(input logic [31:0] addr);
        expect_t                     e;
        logic [`ICACHE_INDEX_LEN-1:0] idx;
        logic [`ICACHE_TAG_LEN-1:0]   tag;
        logic                         way;
        idx         = addr[`ICACHE_OFFT_LEN +: `ICACHE_INDEX_LEN];
        tag         = addr[31 -: `ICACHE_TAG_LEN];
        e.resp.inst = axi_mem_inst.mem_word({addr[31:2], 2'b00});
        // start of the 32-byte line holding addr
        e.ar.addr   = addr & ~(`ICACHE_LINE_BYTES - 1);
        e.hit       = (ref_valid[idx][0] && ref_tag[idx][0] == tag)
                   || (ref_valid[idx][1] && ref_tag[idx][1] == tag);
        if (!e.hit) begin
            // way 1 only when way 0 holds a line and way 1 is empty
            way                 = ref_valid[idx][0] && !ref_valid[idx][1];
            ref_valid[idx][way] = 1'b1;
            ref_tag[idx][way]   = tag;
        end
        return e;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_resp(input string name, input cpu_resp_t exp, input cpu_resp_t act);
        if (exp !== act) begin
            $display("ERR %s: resp expected %h, actual %h", name, exp.inst, act.inst);
            stop_on_error();
        end
    endtask

    task automatic check_ar(input string name, input axi_ar_t exp, input axi_ar_t act);
        if (exp !== act) begin
            $display("ERR %s: ar addr expected %h, actual %h", name, exp.addr, act.addr);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic exp_hit, input logic act_hit);
        if (exp_hit !== act_hit) begin
            $display("ERR %s: outcome expected %s, actual %s", name,
                     exp_hit ? "hit" : "miss", act_hit ? "hit" : "miss");
            stop_on_error();
        end
    endtask

    task automatic check_ready(input string name, input logic exp_rdy, input logic act_rdy);
        if (exp_rdy !== act_rdy) begin
            $display("ERR %s: cpu_ready expected %b, actual %b", name, exp_rdy, act_rdy);
            stop_on_error();
        end
    endtask

    //////////////////////////////////////////////////
    // compare process
    //////////////////////////////////////////////////

    // sampled at the falling edge, all outputs settled
    initial begin
        expect_t e;
        string   nm;
        int      acc;
        logic    act_hit;
        forever begin
            @(negedge I_clk);
            cycle++;
            if (!I_rst) begin
                // ready low from a miss accept through its allocate cycle
                check_ready(test_name, !(pending.size() != 0 && !pending[0].hit), cpu_ready);
                if (ar_valid && ar_ready) begin
                    if (pending.size() == 0 || pending[0].hit) begin
                        $display("AR issued at cycle %0d with no outstanding miss", cycle);
                        stop_on_error();
                    end
                    check_ar(pend_name[0], pending[0].ar, ar);
                    ar_cnt++;
                end
                // response before accept, both can share a cycle
                if (cpu_resp_valid) begin
                    if (pending.size() == 0) begin
                        $display("response at cycle %0d with no request pending", cycle);
                        stop_on_error();
                    end
                    e   = pending.pop_front();
                    nm  = pend_name.pop_front();
                    acc = acc_cycle.pop_front();
                    // a hit answers in the next cycle with no burst
                    act_hit = (cycle == acc + 1) && (ar_cnt == 0);
                    check_flag(nm, e.hit, act_hit);
                    check_resp(nm, e.resp, cpu_resp);
                    if (!e.hit && ar_cnt != 1) begin
                        $display("%s: miss issued %0d read bursts instead of one", nm, ar_cnt);
                        stop_on_error();
                    end
                    ar_cnt = 0;
                end
                if (cpu_req_valid && cpu_ready) begin
                    pending.push_back(ref_access(cpu_req.addr));
                    pend_name.push_back(test_name);
                    acc_cycle.push_back(cycle);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // hold the request until the cache takes it
    task automatic fetch(input logic [31:0] addr);
        cpu_req_valid = 1'b1;
        cpu_req.addr  = addr;
        while (!cpu_ready) begin
            @(posedge I_clk);
            #1;
        end
        @(posedge I_clk);
        #1;
        cpu_req_valid = 1'b0;
    endtask

    initial begin
        logic [31:0] a;
        void'($urandom(32'hfab1));
        I_rst         = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        ref_valid     = '{default: 1'b0};
        repeat (5) @(posedge I_clk);
        #1;
        I_rst = 1'b0;

        // one line per set, tag 2, sets 0..7
        test_name = "cold_miss";
        for (int k = 0; k < 8; k++) fetch(32'h0000_1000 + k * 32 + k * 4);

        // same lines again, back to back
        test_name = "hit_repeat";
        for (int k = 0; k < 8; k++) fetch(32'h0000_1000 + k * 32 + k * 4);

        // set 20, every word of the line
        test_name = "word_select";
        for (int k = 0; k < 8; k++) fetch(32'h0000_2280 + k * 4);

        // set 40 with tags 6 and 10
        test_name = "two_way";
        fetch(32'h0000_3500);
        fetch(32'h0000_5504);
        fetch(32'h0000_3508);
        fetch(32'h0000_551c);
        fetch(32'h0000_3510);

        // tag 14 evicts way 0, tag 10 stays in way 1
        test_name = "replace";
        fetch(32'h0000_7500);
        fetch(32'h0000_7504);
        fetch(32'h0000_5508);
        fetch(32'h0000_350c);

        // 4 tags over 4 sets, forces evictions
        test_name = "random_mix";
        for (int k = 0; k < 300; k++) begin
            a = 32'h0001_0000 + (($urandom % 4) << 11) + (($urandom % 4) << 5)
              + (($urandom % 8) << 2);
            fetch(a);
            if ($urandom % 4 == 0) begin
                @(posedge I_clk);
                #1;
            end
        end

        // let the last response drain
        while (pending.size() != 0) @(posedge I_clk);
        repeat (2) @(posedge I_clk);
        $display("Simulation passed");
        $finish;
    end

    //////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////

    initial begin
        repeat (NUM_REQS * CYCLES_PER_REQ + 10) @(posedge I_clk);
        $display("watchdog expired in test %s, the cache stopped answering", test_name);
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

//--- testbench/tb_axi_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module tb_axi_mem
    import icache_pkg::*;
(
    input  wire logic    I_clk,
    input  wire logic    ar_valid,
    input  wire axi_ar_t ar,
    output logic         ar_ready,
    output logic         r_valid,
    output axi_r_t       r
);

    //////////////////////////////////////////////////
    // memory contents
    //////////////////////////////////////////////////

    // word at byte address addr, mixes every address bit
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] x;
        x = addr ^ 32'h5a5a_0f0f;
        x = x * 32'h9e37_79b1;
        x = x ^ {x[15:0], x[31:16]};
        return x;
    endfunction

    //////////////////////////////////////////////////
    // read burst engine
    //////////////////////////////////////////////////

    // ar accepted after 0..3 cycles, then four beats back to back
    initial begin
        int          delay;
        logic [31:0] base;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        forever begin
            @(posedge I_clk);
            #1;
            if (ar_valid) begin
                delay = $urandom_range(3, 0);
                repeat (delay) begin
                    @(posedge I_clk);
                    #1;
                end
                ar_ready = 1'b1;
                base     = ar.addr;
                @(posedge I_clk);
                #1;
                ar_ready = 1'b0;
                // low half of the line first, little endian words
                for (int beat = 0; beat < `ICACHE_BEATS; beat++) begin
                    r_valid = 1'b1;
                    r.data  = {mem_word(base + beat * 8 + 4), mem_word(base + beat * 8)};
                    r.last  = (beat == `ICACHE_BEATS - 1);
                    @(posedge I_clk);
                    #1;
                end
                r_valid = 1'b0;
                r       = '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module icache_top
    import icache_pkg::*;
(
    input  wire logic     I_clk,
    input  wire logic     I_rst,
    // cpu fetch port
    input  wire logic     cpu_req_valid,
    input  wire cpu_req_t cpu_req,
    output logic          cpu_ready,
    output logic          cpu_resp_valid,
    output cpu_resp_t     cpu_resp,
    // axi read address
    output logic          ar_valid,
    output axi_ar_t       ar,
    input  wire logic     ar_ready,
    // axi read data
    input  wire logic     r_valid,
    input  wire axi_r_t   r
);

    // controller to data ram
    sram_req_t                    sram;
    // data ram back to controller
    logic [`ICACHE_LINE_BITS-1:0] way0_line;
    logic [`ICACHE_LINE_BITS-1:0] way1_line;

    //////////////////////////////////////////////////
    // controller
    //////////////////////////////////////////////////

    icache_ctrl icache_ctrl_inst (
        .I_clk          (I_clk),
        .I_rst          (I_rst),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req        (cpu_req),
        .cpu_ready      (cpu_ready),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp       (cpu_resp),
        .ar_valid       (ar_valid),
        .ar             (ar),
        .ar_ready       (ar_ready),
        .r_valid        (r_valid),
        .r              (r),
        .sram           (sram),
        .way0_line      (way0_line),
        .way1_line      (way1_line)
    );

    //////////////////////////////////////////////////
    // data ram
    //////////////////////////////////////////////////

    icache_data_ram icache_data_ram_inst (
        .I_clk     (I_clk),
        .sram      (sram),
        .way0_line (way0_line),
        .way1_line (way1_line)
    );

endmodule

`default_nettype wire

//--- hw/icache_data_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module icache_data_ram
    import icache_pkg::*;
(
    input  wire logic             I_clk,
    input  wire sram_req_t        sram,
    output logic [`ICACHE_LINE_BITS-1:0] way0_line,
    output logic [`ICACHE_LINE_BITS-1:0] way1_line
);

    //////////////////////////////////////////////////
    // bank layout
    //////////////////////////////////////////////////

    // two half-line banks per way
    localparam int BANKS     = `ICACHE_WAYS * 2;
    localparam int HALF_BITS = `ICACHE_LINE_BITS / 2;
    localparam int DEPTH     = `ICACHE_SETS;

    // per bank read data, zero when bank disabled
    logic [HALF_BITS-1:0] bank_rd [BANKS];

    //////////////////////////////////////////////////
    // banks
    //////////////////////////////////////////////////

    for (genvar b = 0; b < BANKS; b++) begin : g_bank

        // one half line per set
        logic [HALF_BITS-1:0] mem [0:DEPTH-1];

        // even bank takes low half, odd bank high half
        logic [HALF_BITS-1:0] wr_half;

        assign wr_half = sram.wline[(b % 2) * HALF_BITS +: HALF_BITS];

        // write on enable low and write low
        always_ff @(posedge I_clk) begin
            if (!sram.cen_n[b] && !sram.wen_n[b]) begin
                mem[sram.index] <= wr_half;
            end
        end

        // async read of the addressed set
        assign bank_rd[b] = sram.cen_n[b] ? '0 : mem[sram.index];

    end

    //////////////////////////////////////////////////
    // way assembly
    //////////////////////////////////////////////////

    // high bank carries the upper 128 bits
    assign way0_line = {bank_rd[1], bank_rd[0]};
    assign way1_line = {bank_rd[3], bank_rd[2]};

endmodule

`default_nettype wire

//--- hw/icache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  wire logic                         I_clk,
    input  wire logic                         I_rst,
    // cpu fetch side
    input  wire logic                         cpu_req_valid,
    input  wire cpu_req_t                     cpu_req,
    output logic                              cpu_ready,
    output logic                              cpu_resp_valid,
    output cpu_resp_t                         cpu_resp,
    // axi ar channel
    output logic                              ar_valid,
    output axi_ar_t                           ar,
    input  wire logic                         ar_ready,
    // axi r channel, rready tied high
    input  wire logic                         r_valid,
    input  wire axi_r_t                       r,
    // data ram
    output sram_req_t                         sram,
    input  wire logic [`ICACHE_LINE_BITS-1:0] way0_line,
    input  wire logic [`ICACHE_LINE_BITS-1:0] way1_line
);

    localparam int OFFT_LEN  = `ICACHE_OFFT_LEN;
    localparam int INDEX_LEN = `ICACHE_INDEX_LEN;
    localparam int TAG_LEN   = `ICACHE_TAG_LEN;
    localparam int LINE_BITS = `ICACHE_LINE_BITS;
    // bits kept from the line reg on each beat shift
    localparam int KEEP_BITS = (`ICACHE_BEATS - 1) * `ICACHE_BEAT_BITS;

    //////////////////////////////////////////////////
    // address split
    //////////////////////////////////////////////////

    // incoming request fields
    logic [TAG_LEN-1:0]   req_tag;
    logic [INDEX_LEN-1:0] req_index;

    // latched request, used by miss path and response mux
    logic [31:0]          addr_q;
    logic [TAG_LEN-1:0]   tag_q;
    logic [INDEX_LEN-1:0] index_q;
    logic [OFFT_LEN-1:0]  offt_q;

    assign req_tag   = cpu_req.addr[31 -: TAG_LEN];
    assign req_index = cpu_req.addr[OFFT_LEN +: INDEX_LEN];

    assign tag_q   = addr_q[31 -: TAG_LEN];
    assign index_q = addr_q[OFFT_LEN +: INDEX_LEN];
    assign offt_q  = addr_q[OFFT_LEN-1:0];

    //////////////////////////////////////////////////
    // tag / valid store
    //////////////////////////////////////////////////

    // entry = {set, way}, way in the lsb
    logic [TAG_LEN-1:0]         tag_mem [0:`ICACHE_ENTRIES-1];
    logic [`ICACHE_ENTRIES-1:0] valid_q;

    logic [TAG_LEN-1:0] way0_tag;
    logic [TAG_LEN-1:0] way1_tag;
    logic               way0_valid;
    logic               way1_valid;

    // lookup of the set addressed by the live request
    assign way0_tag   = tag_mem[{req_index, 1'b0}];
    assign way1_tag   = tag_mem[{req_index, 1'b1}];
    assign way0_valid = valid_q[{req_index, 1'b0}];
    assign way1_valid = valid_q[{req_index, 1'b1}];

    //////////////////////////////////////////////////
    // hit / miss
    //////////////////////////////////////////////////

    icache_state_e state_q;
    icache_state_e state_d;

    logic req_fire;
    logic way0_hit;
    logic way1_hit;
    logic hit;
    logic miss;
    logic allocate;

    // only accepted requests look up
    assign req_fire = cpu_req_valid && cpu_ready;

    assign way0_hit = req_fire && way0_valid && (way0_tag == req_tag);
    assign way1_hit = req_fire && way1_valid && (way1_tag == req_tag);
    assign hit      = way0_hit || way1_hit;
    assign miss     = req_fire && !hit;
    assign allocate = (state_q == ST_ALLOCATE);

    //////////////////////////////////////////////////
    // replacement
    //////////////////////////////////////////////////

    logic                 fill_way1;
    logic [INDEX_LEN:0]   fill_entry;

    // way 1 only if way 0 taken and way 1 free
    assign fill_way1  = valid_q[{index_q, 1'b0}] && !valid_q[{index_q, 1'b1}];
    assign fill_entry = {index_q, fill_way1};

    // valid bits, cleared on reset
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            valid_q <= '0;
        end else if (allocate) begin
            valid_q[fill_entry] <= 1'b1;
        end
    end

    // tags follow the valid bits
    always_ff @(posedge I_clk) begin
        if (allocate) begin
            tag_mem[fill_entry] <= tag_q;
        end
    end

    //////////////////////////////////////////////////
    // request latch and line register
    //////////////////////////////////////////////////

    always_ff @(posedge I_clk) begin
        if (req_fire) begin
            addr_q <= cpu_req.addr;
        end
    end

    logic [LINE_BITS-1:0] line_q;

    // hit: grab the way line
    // reload: beats enter at the top, low beat first
    always_ff @(posedge I_clk) begin
        if (hit) begin
            line_q <= way0_hit ? way0_line : way1_line;
        end else if ((state_q == ST_RELOAD) && r_valid) begin
            line_q <= {r.data, line_q[LINE_BITS-1 -: KEEP_BITS]};
        end
    end

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            // idle and hit both take new requests
            ST_IDLE, ST_HIT: begin
                if (hit) begin
                    state_d = ST_HIT;
                end else if (miss) begin
                    state_d = ST_MISS;
                end else begin
                    state_d = ST_IDLE;
                end
            end
            // hold ar until accepted
            ST_MISS: begin
                if (ar_ready) begin
                    state_d = ST_RELOAD;
                end
            end
            // collect beats up to last
            ST_RELOAD: begin
                if (r_valid && r.last) begin
                    state_d = ST_ALLOCATE;
                end
            end
            // single cycle write + response
            ST_ALLOCATE: state_d = ST_IDLE;
            default:     state_d = ST_IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // sram control
    //////////////////////////////////////////////////

    // banks 1:0 are way 0, banks 3:2 are way 1
    always_comb begin
        sram.index = hit ? req_index : index_q;
        sram.cen_n = 4'b1111;
        sram.wen_n = 4'b1111;
        sram.wline = line_q;
        if (hit) begin
            // read the hitting way only
            sram.cen_n = way0_hit ? 4'b1100 : 4'b0011;
        end else if (allocate) begin
            // whole line write into the chosen way
            sram.cen_n = fill_way1 ? 4'b0011 : 4'b1100;
            sram.wen_n = 4'b0000;
        end
    end

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    logic [OFFT_LEN-3:0] word_sel;

    assign word_sel = offt_q[OFFT_LEN-1:2];

    assign cpu_ready      = (state_q == ST_IDLE) || (state_q == ST_HIT);
    assign cpu_resp_valid = (state_q == ST_HIT) || allocate;
    // 32-bit word picked by latched offset
    assign cpu_resp.inst  = line_q[{word_sel, 5'd0} +: 32];

    assign ar_valid = (state_q == ST_MISS);
    assign ar.addr  = {addr_q[31:OFFT_LEN], {OFFT_LEN{1'b0}}};

endmodule

`default_nettype wire

//--- hw/icache_pkg.sv
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

    //////////////////////////////////////////////////
    // controller FSM
    //////////////////////////////////////////////////

    // idle -> hit | miss, miss -> reload -> allocate -> idle
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HIT,
        ST_MISS,
        ST_RELOAD,
        ST_ALLOCATE
    } icache_state_e;

    //////////////////////////////////////////////////
    // cpu fetch port
    //////////////////////////////////////////////////

    // fetch address, byte granular
    typedef struct packed {
        logic [31:0] addr;
    } cpu_req_t;

    // returned instruction word
    typedef struct packed {
        logic [31:0] inst;
    } cpu_resp_t;

    //////////////////////////////////////////////////
    // axi read channels
    //////////////////////////////////////////////////

    // ar payload, always line aligned
    typedef struct packed {
        logic [31:0] addr;
    } axi_ar_t;

    // r payload, one 8-byte beat
    typedef struct packed {
        logic [`ICACHE_BEAT_BITS-1:0] data;
        logic                         last;
    } axi_r_t;

    // data ram control, all strobes active low
    typedef struct packed {
        logic [`ICACHE_INDEX_LEN-1:0] index;
        logic [3:0]                   cen_n;
        logic [3:0]                   wen_n;
        logic [`ICACHE_LINE_BITS-1:0] wline;
    } sram_req_t;

endpackage

`default_nettype wire

//--- hw/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

//////////////////////////////////////////////////
// cache geometry
//////////////////////////////////////////////////

// bytes per cache line
`define ICACHE_LINE_BYTES 32
// whole cache, both ways
`define ICACHE_SIZE_BYTES 4096
// two-way set associative
`define ICACHE_WAYS 2

// derived counts
`define ICACHE_SETS (`ICACHE_SIZE_BYTES / `ICACHE_LINE_BYTES / `ICACHE_WAYS)
`define ICACHE_ENTRIES (`ICACHE_SETS * `ICACHE_WAYS)

//////////////////////////////////////////////////
// address fields: tag | index | offset
//////////////////////////////////////////////////

`define ICACHE_OFFT_LEN 5
`define ICACHE_INDEX_LEN 6
`define ICACHE_TAG_LEN 21

// line and beat widths
`define ICACHE_LINE_BITS (`ICACHE_LINE_BYTES * 8)
`define ICACHE_BEAT_BITS 64
`define ICACHE_BEATS (`ICACHE_LINE_BITS / `ICACHE_BEAT_BITS)

`endif
